// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - cpuPkg.sv
  - decoder.sv
  - decodeExecReg.sv
  - condUnit.sv
  - imageMemCtrl.sv
  - controlUnit.sv
  - target: simulation
    files:
      - controlUnitChecker.sv
      - controlUnitTb.sv

// ==== condUnit.sv ====
`timescale 1ns/1ps

module condUnit (
	input  logic            clk,
	input  logic            reset,
	input  cpuPkg::condT    condE,
	input  logic [1:0]      flagWriteE,
	input  logic            pcSrcE,
	input  logic            regWriteE,
	input  logic            memWriteE,
	input  cpuPkg::memCtrlT memCtrlE,
	input  cpuPkg::flagsT   aluFlags,
	output logic            pcSrcG,
	output logic            regWriteG,
	output logic            memWriteG,
	output cpuPkg::memCtrlT memCtrlG,
	output cpuPkg::flagsT   flags
);
	import cpuPkg::*;

	logic n;
	logic z;
	logic c;
	logic v;
	logic condEx;

	assign {n, z, c, v} = flags;

	// ARM condition table against the stored flags
	always_comb begin
		case (condE)
			CondEq:  condEx = z;
			CondNe:  condEx = ~z;
			CondCs:  condEx = c;
			CondCc:  condEx = ~c;
			CondMi:  condEx = n;
			CondPl:  condEx = ~n;
			CondVs:  condEx = v;
			CondVc:  condEx = ~v;
			CondHi:  condEx = c & ~z;
			CondLs:  condEx = ~c | z;
			CondGe:  condEx = (n == v);
			CondLt:  condEx = (n != v);
			CondGt:  condEx = ~z & (n == v);
			CondLe:  condEx = z | (n != v);
			default: condEx = 1'b1;    // AL and 1111
		endcase
	end

	// Side effects only for executed instructions
	assign pcSrcG    = pcSrcE & condEx;
	assign regWriteG = regWriteE & condEx;
	assign memWriteG = memWriteE & condEx;
	assign memCtrlG  = condEx ? memCtrlE : '0;

	// N/Z and C/V load independently
	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
		end else if (condEx) begin
			if (flagWriteE[1])
				flags[3:2] <= aluFlags[3:2];
			if (flagWriteE[0])
				flags[1:0] <= aluFlags[1:0];
		end
	end

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
	input  logic            clk,
	input  logic            reset,
	input  logic            stall,
	input  logic            flush,
	input  cpuPkg::instrT   instr,
	input  cpuPkg::flagsT   aluFlags,
	output logic            memToRegE,
	output logic            aluSrcE,
	output logic [1:0]      immSrcE,
	output logic [1:0]      regSrcE,
	output cpuPkg::aluCtrlT aluControlE,
	output logic            branchE,
	output logic            pcSrcG,
	output logic            regWriteG,
	output logic            memWriteG,
	output cpuPkg::flagsT   flags,
	output logic            ramWrite,
	output logic            kernelRead,
	output logic            romRead,
	output logic            memWbSel,
	output cpuPkg::pixAddrT pixelAddr,
	output cpuPkg::kernIdxT kernelIdx,
	output cpuPkg::pixAddrT ramAddr
);
	import cpuPkg::*;

	// Instruction fields
	condT    cond;
	opT      op;
	functT   funct;
	regAddrT rd;

	// Decode stage controls
	logic [1:0] flagWrite;
	logic       pcSrc;
	logic       regWrite;
	logic       memWrite;
	logic       memToReg;
	logic       aluSrc;
	logic [1:0] immSrc;
	logic [1:0] regSrc;
	aluCtrlT    aluControl;
	logic       branch;
	memCtrlT    memCtrl;

	// Execute stage controls before gating
	condT       condE;
	logic [1:0] flagWriteE;
	logic       pcSrcE;
	logic       regWriteE;
	logic       memWriteE;
	memCtrlT    memCtrlE;
	memCtrlT    memCtrlG;

	assign cond  = instr[CondMsb -: $bits(condT)];
	assign op    = instr[OpMsb -: $bits(opT)];
	assign funct = instr[FunctMsb -: $bits(functT)];
	assign rd    = instr[RdMsb -: $bits(regAddrT)];

	decoder u_decoder (
		.op, .funct, .rd,
		.flagWrite, .pcSrc, .regWrite, .memWrite, .memToReg, .aluSrc,
		.immSrc, .regSrc, .aluControl, .branch, .memCtrl
	);

	decodeExecReg u_decodeExecReg (
		.clk, .reset, .stall, .flush,
		.cond, .flagWrite, .pcSrc, .regWrite, .memWrite, .memToReg, .aluSrc,
		.immSrc, .regSrc, .aluControl, .branch, .memCtrl,
		.condE, .flagWriteE, .pcSrcE, .regWriteE, .memWriteE, .memToRegE, .aluSrcE,
		.immSrcE, .regSrcE, .aluControlE, .branchE, .memCtrlE
	);

	condUnit u_condUnit (
		.clk, .reset,
		.condE, .flagWriteE, .pcSrcE, .regWriteE, .memWriteE, .memCtrlE, .aluFlags,
		.pcSrcG, .regWriteG, .memWriteG, .memCtrlG, .flags
	);

	imageMemCtrl u_imageMemCtrl (
		.clk, .reset,
		.memCtrl (memCtrlG),    // Gated word drives strobes and pointers
		.ramWrite, .kernelRead, .romRead, .memWbSel,
		.pixelAddr, .kernelIdx, .ramAddr
	);

endmodule

// ==== controlUnitChecker.sv ====
`timescale 1ns/1ps

module controlUnitChecker (
	input  logic            clk,
	input  logic            reset,
	input  logic            stall,
	input  logic            flush,
	input  cpuPkg::instrT   instr,
	input  cpuPkg::flagsT   aluFlags,
	input  logic            memToRegE,
	input  logic            aluSrcE,
	input  logic [1:0]      immSrcE,
	input  logic [1:0]      regSrcE,
	input  cpuPkg::aluCtrlT aluControlE,
	input  logic            branchE,
	input  logic            pcSrcG,
	input  logic            regWriteG,
	input  logic            memWriteG,
	input  cpuPkg::flagsT   flags,
	input  logic            ramWrite,
	input  logic            kernelRead,
	input  logic            romRead,
	input  logic            memWbSel,
	input  cpuPkg::pixAddrT pixelAddr,
	input  cpuPkg::kernIdxT kernelIdx,
	input  cpuPkg::pixAddrT ramAddr,
	output int              errorCount,
	output int              checkCount
);
	import cpuPkg::*;

	// Control word layout: {flagWrite[22:21], pcSrc, regWrite, memWrite, memToReg, aluSrc,
	// immSrc[15:14], regSrc[13:12], aluControl[11:8], branch, memCtrl[6:0]}
	logic [3:0]  mCond;
	logic [22:0] mCtrl;    // Execute stage model
	flagsT       mFlags;
	pixAddrT     mPixel;
	kernIdxT     mKernel;
	pixAddrT     mRam;
	logic        execEdge;
	memCtrlT     gatedEdge;
	logic        execNow;
	memCtrlT     gatedNow;

	function automatic logic [22:0] refDecode(input opT op, input functT funct, input regAddrT rd);
		logic       isDp;
		logic       isLdr;
		logic       isStr;
		logic       isBr;
		logic       isKern;
		logic       isSave;
		logic       isPix;
		logic       wr;
		logic [1:0] fw;
		logic [3:0] alu;
		memCtrlT    mc;
		isDp   = (op == 3'b000);
		isLdr  = (op == 3'b001) && funct[0];    // L bit
		isStr  = (op == 3'b001) && !funct[0];
		isBr   = (op == 3'b010);
		isKern = (op == 3'b100);
		isSave = (op == 3'b101);
		isPix  = (op == 3'b110);
		wr     = isDp | isLdr | isKern | isPix;
		alu    = 4'b0011;    // Address add
		fw     = 2'b00;
		if (isDp | isKern | isSave | isPix) begin
			case (funct[4:1])
				4'b0001: alu = 4'b0110;    // Multiply
				4'b0010: alu = 4'b0010;    // Subtract
				4'b0011: alu = 4'b0111;    // Concatenate
				4'b0100: alu = 4'b0011;    // Add
				4'b1100: alu = 4'b0101;    // Scale
				4'b1101: alu = 4'b0001;    // Dot product
				4'b1111: alu = 4'b0100;    // Compare
				default: alu = 4'b0000;    // Vector add
			endcase
			// C and V follow S only for add and subtract
			fw = {funct[0], funct[0] && (funct[4:1] == 4'b0100 || funct[4:1] == 4'b0010)};
		end
		mc             = '0;
		mc[McSecEn]    = isKern | isPix;
		mc[McRead]     = isKern | isPix;
		mc[McRomSel]   = isPix;
		mc[McStep]     = isPix | (isKern & funct[5]);
		mc[McWbSel]    = isKern | isSave;
		mc[McRamWrite] = isSave;
		refDecode = {fw, (wr && rd == PcReg) || isBr, wr, isStr | isSave,
			isLdr | isStr | isKern | isPix, (isDp & funct[5]) | isLdr | isStr | isBr | isSave,
			isBr ? 2'b10 : {1'b0, isLdr | isStr}, (isStr | isSave) ? 2'b10 : 2'b00,
			alu, isBr, mc};
	endfunction

	function automatic logic refCond(input logic [3:0] cond, input flagsT f);
		logic n;
		logic z;
		logic c;
		logic v;
		{n, z, c, v} = f;
		case (cond)
			4'b0000: refCond = z;
			4'b0001: refCond = !z;
			4'b0010: refCond = c;
			4'b0011: refCond = !c;
			4'b0100: refCond = n;
			4'b0101: refCond = !n;
			4'b0110: refCond = v;
			4'b0111: refCond = !v;
			4'b1000: refCond = c && !z;    // HI
			4'b1001: refCond = !c || z;
			4'b1010: refCond = (n == v);
			4'b1011: refCond = (n != v);
			4'b1100: refCond = !z && (n == v);
			4'b1101: refCond = z || (n != v);
			default: refCond = 1'b1;
		endcase
	endfunction

	task automatic compareField(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	initial begin
		errorCount = 0;
		checkCount = 0;
	end

	// Model advances on the DUT's edges, old contents used first
	always @(posedge clk) begin
		if (reset) begin
			mCond   = 4'b1110;
			mCtrl   = '0;
			mFlags  = '0;
			mPixel  = '0;
			mKernel = '0;
			mRam    = '0;
		end else begin
			execEdge  = refCond(mCond, mFlags);
			gatedEdge = execEdge ? mCtrl[6:0] : '0;
			if (execEdge && mCtrl[22])
				mFlags[3:2] = aluFlags[3:2];    // N and Z
			if (execEdge && mCtrl[21])
				mFlags[1:0] = aluFlags[1:0];    // C and V
			if (gatedEdge[McSecEn] && gatedEdge[McRead] && gatedEdge[McStep]) begin
				if (gatedEdge[McRomSel])
					mPixel = mPixel + 1'b1;
				else
					mKernel = (mKernel == KernelSize - 1) ? '0 : mKernel + 1'b1;
			end
			if (gatedEdge[McRamWrite])
				mRam = mRam + 1'b1;
			if (flush) begin
				mCond = 4'b1110;    // Bubble
				mCtrl = '0;
			end else if (!stall) begin
				mCond = instr[CondMsb -: 4];
				mCtrl = refDecode(instr[OpMsb -: 3], instr[FunctMsb -: 6], instr[RdMsb -: 5]);
			end
		end
	end

	// Outputs are settled half a cycle after the edge
	always @(negedge clk) begin
		if (!reset) begin
			execNow  = refCond(mCond, mFlags);
			gatedNow = execNow ? mCtrl[6:0] : '0;
			compareField("execute controls", mCtrl[17:7],
				{memToRegE, aluSrcE, immSrcE, regSrcE, aluControlE, branchE});
			compareField("gated enables", mCtrl[20:18] & {3{execNow}},
				{pcSrcG, regWriteG, memWriteG});
			compareField("flags", mFlags, flags);
			compareField("strobes", {gatedNow[McRamWrite],
				gatedNow[McSecEn] & gatedNow[McRead] & !gatedNow[McRomSel],
				gatedNow[McSecEn] & gatedNow[McRead] & gatedNow[McRomSel], gatedNow[McWbSel]},
				{ramWrite, kernelRead, romRead, memWbSel});
			compareField("pixelAddr", mPixel, pixelAddr);
			compareField("kernelIdx", mKernel, kernelIdx);
			compareField("ramAddr", mRam, ramAddr);
		end
	end

endmodule

// ==== controlUnitTb.sv ====
`timescale 1ns/1ps

module controlUnitTb;
	import cpuPkg::*;

	localparam int ClkPeriod   = 8;
	localparam int ResetCycles = 10;
	localparam int IdleLimit   = 20;

	logic       clk;
	logic       reset;
	logic       stall;
	logic       flush;
	instrT      instr;
	flagsT      aluFlags;
	logic       memToRegE;
	logic       aluSrcE;
	logic [1:0] immSrcE;
	logic [1:0] regSrcE;
	aluCtrlT    aluControlE;
	logic       branchE;
	logic       pcSrcG;
	logic       regWriteG;
	logic       memWriteG;
	flagsT      flags;
	logic       ramWrite;
	logic       kernelRead;
	logic       romRead;
	logic       memWbSel;
	pixAddrT    pixelAddr;
	kernIdxT    kernelIdx;
	pixAddrT    ramAddr;
	int         errorCount;
	int         checkCount;
	int         lastErrors;
	int         testCount;
	bit         idleTimeout;
	integer     seed;
	int         i;
	int         k;
	functT      f;

	always #(ClkPeriod / 2) clk = ~clk;

	controlUnit u_controlUnit (.*);

	controlUnitChecker u_controlUnitChecker (.*);

	// One instruction per cycle with fresh ALU flags
	task automatic issue(input logic [3:0] cond, input opT op, input functT funct,
		input regAddrT rd);
		logic [13:0] filler;
		filler   = $random(seed);
		instr    = {cond, op, funct, rd, filler};
		aluFlags = $random(seed);
		@(posedge clk);
		#1;
	endtask

	function automatic logic outputsIdle();
		outputsIdle = {pcSrcG, regWriteG, memWriteG, ramWrite, kernelRead, romRead,
			memWbSel} === 7'b0 && flags === '0 && pixelAddr === '0 && kernelIdx === '0
			&& ramAddr === '0;
	endfunction

	task automatic waitIdle(input string what);
		int cycles;
		cycles = 0;
		while (!outputsIdle() && cycles < IdleLimit) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!outputsIdle()) begin
			$display("Timeout: outputs still active %0d cycles after %s", IdleLimit, what);
			idleTimeout = 1'b1;
		end
	endtask

	task automatic endTest(input string name);
		instr = {CondAl, 3'b011, 25'b0};    // Undefined opcode has no effect
		@(posedge clk);
		#1;
		testCount++;
		$display("Test %0d %s: %0d mismatches", testCount, name, errorCount - lastErrors);
		lastErrors = errorCount;
	endtask

	initial begin
		clk         = 1'b0;
		reset       = 1'b1;
		stall       = 1'b0;
		flush       = 1'b0;
		instr       = {CondAl, 3'b011, 25'b0};
		aluFlags    = '0;
		seed        = 32'h1df2_097b;
		lastErrors  = 0;
		testCount   = 0;
		idleTimeout = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		#1;
		reset = 1'b0;
		waitIdle("power-on reset");

		// All opcodes and every ALU code for data processing
		for (i = 0; i < 8; i++) begin
			for (k = 0; k < 16; k++) begin
				f = $random(seed);
				if (i == 0)
					f[4:1] = k[3:0];
				issue(CondAl, i[2:0], f, $random(seed));
			end
		end
		issue(CondAl, 3'b000, 6'b001000, 5'd15);    // Add into the PC
		issue(CondAl, 3'b001, 6'b000001, 5'd15);    // Load into the PC
		endTest("decode table");

		for (i = 0; i < 48; i++) begin
			f = $random(seed);
			if (i % 3 == 0)
				f[4:1] = 4'b0100;
			else if (i % 3 == 1)
				f[4:1] = 4'b0010;
			issue(CondAl, 3'b000, f, $random(seed));
		end
		endTest("flag writes");

		for (i = 0; i < 64; i++) begin
			k = $unsigned($random(seed)) % 6;
			issue($random(seed), (k < 3) ? k[2:0] : k[2:0] + 3'd1, $random(seed), $random(seed));
		end
		endTest("condition gating");

		// Pixel reads, kernel reads with random step and picture saves
		for (i = 0; i < 80; i++) begin
			k = $unsigned($random(seed)) % 3;
			issue(CondAl, 3'b100 + k[2:0], $random(seed), $random(seed));
		end
		endTest("image pointers");

		issue(CondAl, 3'b000, 6'b101001, 5'd3);
		stall = 1'b1;    // Held instruction is data processing
		for (i = 0; i < 4; i++)
			issue(CondAl, 3'b000, $random(seed), $random(seed));
		flush = 1'b1;
		issue(CondAl, 3'b110, $random(seed), $random(seed));
		stall = 1'b0;
		issue(CondAl, 3'b100, $random(seed), $random(seed));
		flush = 1'b0;
		issue(CondAl, 3'b010, $random(seed), $random(seed));
		endTest("stall and flush");

		for (i = 0; i < 6; i++)
			issue(CondAl, 3'b100 + i % 3, 6'b100000, $random(seed));
		instr = {CondAl, 3'b011, 25'b0};
		reset = 1'b1;
		repeat (ResetCycles) @(posedge clk);
		#1;
		reset = 1'b0;
		waitIdle("reset during operation");
		endTest("reset");

		$display("Tests: %0d, checks: %0d, mismatches: %0d", testCount, checkCount, errorCount);
		if (errorCount == 0 && !idleTimeout)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

	// Plain vector types with a meaning
	typedef logic [31:0] instrT;
	typedef logic [3:0]  condT;
	typedef logic [2:0]  opT;
	typedef logic [5:0]  functT;
	typedef logic [4:0]  regAddrT;
	typedef logic [3:0]  aluCtrlT;
	typedef logic [3:0]  flagsT;    // {N, Z, C, V}
	typedef logic [6:0]  memCtrlT;
	typedef logic [15:0] pixAddrT;
	typedef logic [3:0]  kernIdxT;

	// ARM condition codes, 4'b1111 is treated as always
	typedef enum logic [3:0] {
		CondEq = 4'b0000,
		CondNe = 4'b0001,
		CondCs = 4'b0010,
		CondCc = 4'b0011,
		CondMi = 4'b0100,
		CondPl = 4'b0101,
		CondVs = 4'b0110,
		CondVc = 4'b0111,
		CondHi = 4'b1000,
		CondLs = 4'b1001,
		CondGe = 4'b1010,
		CondLt = 4'b1011,
		CondGt = 4'b1100,
		CondLe = 4'b1101,
		CondAl = 4'b1110
	} condCodeE;

	// Instruction field positions
	localparam int CondMsb  = 31;
	localparam int OpMsb    = 27;
	localparam int FunctMsb = 24;
	localparam int RdMsb    = 18;

	localparam int PcReg = 15;

	// Memory control word bits, bit 4 reserved
	localparam int McRamWrite = 0;
	localparam int McRead     = 1;
	localparam int McRomSel   = 2;
	localparam int McStep     = 3;
	localparam int McWbSel    = 5;
	localparam int McSecEn    = 6;

	localparam int KernelSize = 9;    // Coefficients per kernel

endpackage

// ==== decodeExecReg.sv ====
`timescale 1ns/1ps

module decodeExecReg (
	input  logic            clk,
	input  logic            reset,
	input  logic            stall,
	input  logic            flush,
	input  cpuPkg::condT    cond,
	input  logic [1:0]      flagWrite,
	input  logic            pcSrc,
	input  logic            regWrite,
	input  logic            memWrite,
	input  logic            memToReg,
	input  logic            aluSrc,
	input  logic [1:0]      immSrc,
	input  logic [1:0]      regSrc,
	input  cpuPkg::aluCtrlT aluControl,
	input  logic            branch,
	input  cpuPkg::memCtrlT memCtrl,
	output cpuPkg::condT    condE,
	output logic [1:0]      flagWriteE,
	output logic            pcSrcE,
	output logic            regWriteE,
	output logic            memWriteE,
	output logic            memToRegE,
	output logic            aluSrcE,
	output logic [1:0]      immSrcE,
	output logic [1:0]      regSrcE,
	output cpuPkg::aluCtrlT aluControlE,
	output logic            branchE,
	output cpuPkg::memCtrlT memCtrlE
);
	import cpuPkg::*;

	always_ff @(posedge clk) begin
		if (reset || flush) begin    // Bubble, flush beats stall
			condE       <= CondAl;
			flagWriteE  <= '0;
			pcSrcE      <= 1'b0;
			regWriteE   <= 1'b0;
			memWriteE   <= 1'b0;
			memToRegE   <= 1'b0;
			aluSrcE     <= 1'b0;
			immSrcE     <= '0;
			regSrcE     <= '0;
			aluControlE <= '0;
			branchE     <= 1'b0;
			memCtrlE    <= '0;
		end else if (!stall) begin
			condE       <= cond;
			flagWriteE  <= flagWrite;
			pcSrcE      <= pcSrc;
			regWriteE   <= regWrite;
			memWriteE   <= memWrite;
			memToRegE   <= memToReg;
			aluSrcE     <= aluSrc;
			immSrcE     <= immSrc;
			regSrcE     <= regSrc;
			aluControlE <= aluControl;
			branchE     <= branch;
			memCtrlE    <= memCtrl;
		end
	end

endmodule

// ==== decoder.sv ====
`timescale 1ns/1ps

module decoder (
	input  cpuPkg::opT      op,
	input  cpuPkg::functT   funct,
	input  cpuPkg::regAddrT rd,
	output logic [1:0]      flagWrite,
	output logic            pcSrc,
	output logic            regWrite,
	output logic            memWrite,
	output logic            memToReg,
	output logic            aluSrc,
	output logic [1:0]      immSrc,
	output logic [1:0]      regSrc,
	output cpuPkg::aluCtrlT aluControl,
	output logic            branch,
	output cpuPkg::memCtrlT memCtrl
);
	import cpuPkg::*;

	logic [9:0] controls;    // {regSrc, immSrc, aluSrc, memToReg, regWrite, memWrite, branch, aluOp}
	logic       aluOp;

	// Main control word and memory control word per opcode
	always_comb begin
		memCtrl = '0;
		case (op)
			3'b000: controls = funct[5] ? 10'b0000101001 : 10'b0000001001;    // Data processing
			3'b001: controls = funct[0] ? 10'b0001111000 : 10'b1001110100;    // LDR / STR
			3'b010: controls = 10'b0010100010;                                // Branch
			3'b100: begin    // Kernel read
				controls            = 10'b0000011001;
				memCtrl[McSecEn]    = 1'b1;
				memCtrl[McWbSel]    = 1'b1;
				memCtrl[McRead]     = 1'b1;
				memCtrl[McStep]     = funct[5];    // Step bit walks the kernel
			end
			3'b101: begin    // Picture save
				controls            = 10'b1000100101;
				memCtrl[McWbSel]    = 1'b1;
				memCtrl[McRamWrite] = 1'b1;
			end
			3'b110: begin    // Pixel read
				controls          = 10'b0000011001;
				memCtrl[McSecEn]  = 1'b1;
				memCtrl[McStep]   = 1'b1;
				memCtrl[McRomSel] = 1'b1;
				memCtrl[McRead]   = 1'b1;
			end
			default: controls = '0;    // Unknown opcode acts as a no-op
		endcase
	end

	assign {regSrc, immSrc, aluSrc, memToReg, regWrite, memWrite, branch, aluOp} = controls;

	// ALU operation and flag write enables
	always_comb begin
		if (aluOp) begin
			case (funct[4:1])
				4'b0000: aluControl = 4'b0000;    // Vector add
				4'b0001: aluControl = 4'b0110;    // Multiply
				4'b0010: aluControl = 4'b0010;    // Subtract
				4'b0011: aluControl = 4'b0111;    // Concatenate
				4'b0100: aluControl = 4'b0011;    // Add
				4'b1100: aluControl = 4'b0101;    // Scale
				4'b1101: aluControl = 4'b0001;    // Dot product
				4'b1111: aluControl = 4'b0100;    // Compare
				default: aluControl = 4'b0000;
			endcase

			// S bit enables N/Z, C/V only for add and subtract
			flagWrite[1] = funct[0];
			flagWrite[0] = funct[0] & ((aluControl == 4'b0011) | (aluControl == 4'b0010));
		end else begin
			aluControl = 4'b0011;    // Address and branch target add
			flagWrite  = 2'b00;
		end
	end

	// Writing the PC register behaves like a branch
	assign pcSrc = ((rd == regAddrT'(PcReg)) & regWrite) | branch;

endmodule

// ==== filelist.f ====
cpuPkg.sv
decoder.sv
decodeExecReg.sv
condUnit.sv
imageMemCtrl.sv
controlUnit.sv
controlUnitChecker.sv
controlUnitTb.sv

// ==== imageMemCtrl.sv ====
`timescale 1ns/1ps

module imageMemCtrl (
	input  logic            clk,
	input  logic            reset,
	input  cpuPkg::memCtrlT memCtrl,
	output logic            ramWrite,
	output logic            kernelRead,
	output logic            romRead,
	output logic            memWbSel,
	output cpuPkg::pixAddrT pixelAddr,
	output cpuPkg::kernIdxT kernelIdx,
	output cpuPkg::pixAddrT ramAddr
);
	import cpuPkg::*;

	logic secRead;
	logic step;

	assign secRead = memCtrl[McSecEn] & memCtrl[McRead];
	assign step    = memCtrl[McStep];

	// Strobes straight from the gated control word
	assign ramWrite   = memCtrl[McRamWrite];
	assign kernelRead = secRead & ~memCtrl[McRomSel];
	assign romRead    = secRead & memCtrl[McRomSel];
	assign memWbSel   = memCtrl[McWbSel];

	// Pixel pointer into the ROM
	always_ff @(posedge clk) begin
		if (reset)
			pixelAddr <= '0;
		else if (romRead && step)
			pixelAddr <= pixelAddr + pixAddrT'(1);
	end

	// Kernel coefficient index wraps at the kernel size
	always_ff @(posedge clk) begin
		if (reset) begin
			kernelIdx <= '0;
		end else if (kernelRead && step) begin
			if (kernelIdx == kernIdxT'(KernelSize - 1))
				kernelIdx <= '0;
			else
				kernelIdx <= kernelIdx + kernIdxT'(1);
		end
	end

	// Output position in the picture RAM
	always_ff @(posedge clk) begin
		if (reset)
			ramAddr <= '0;
		else if (ramWrite)
			ramAddr <= ramAddr + pixAddrT'(1);
	end

endmodule
